/* source/cdma_cfg.svh */
//////////////////////////////////////////////////
// cdma configuration: port count, descriptor
// queue depth and register byte offsets
//////////////////////////////////////////////////
`ifndef CDMA_CFG_SVH
`define CDMA_CFG_SVH

// two cores and one peripheral port
`define CDMA_NUM_PORTS 3

// backend descriptor queue depth, also the initial credit count
`define CDMA_DESC_DEPTH 4

// register byte offsets, only bits 4 to 2 are decoded
`define CDMA_REG_SRC    32'h00
`define CDMA_REG_DST    32'h04
`define CDMA_REG_LEN    32'h08
`define CDMA_REG_LAUNCH 32'h10
`define CDMA_REG_STATUS 32'h14

`endif

/* source/cdma_pkg.sv */
//////////////////////////////////////////////////
// cdma shared types for words, addresses, ids
// and transfer descriptors
//////////////////////////////////////////////////
`default_nettype none
`include "cdma_cfg.svh"

package cdma_pkg;

    // one data word on the register and memory ports
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // transfer id, also used for the completed count
    typedef logic [31:0] xfer_id_t;

    // one 1d copy job
    typedef struct packed {
        word_t num_bytes;
        addr_t dst_addr;
        addr_t src_addr;
    } desc_t;

    // requester index
    localparam int unsigned port_idx_w =
        (`CDMA_NUM_PORTS > 1) ? $clog2(`CDMA_NUM_PORTS) : 1;

    typedef logic [port_idx_w-1:0] port_idx_t;

endpackage

`default_nettype wire

/* source/cdma_cfg_regs.sv */
//////////////////////////////////////////////////
// cdma register set for one requester with the
// launch handshake and the registered response
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cdma_cfg.svh"

module cdma_cfg_regs (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               req_i,
    input  logic               we_i,
    input  cdma_pkg::addr_t    addr_i,
    input  cdma_pkg::word_t    wdata_i,
    output logic               gnt_o,
    output logic               r_valid_o,
    output cdma_pkg::word_t    r_data_o,
    output logic               launch_req_o,
    input  logic               launch_gnt_i,
    input  cdma_pkg::xfer_id_t launch_id_i,
    input  cdma_pkg::xfer_id_t done_count_i,
    output cdma_pkg::desc_t    desc_o
);
    import cdma_pkg::*;

    // word index of each register
    localparam logic [2:0] idx_src    = 3'(`CDMA_REG_SRC >> 2);
    localparam logic [2:0] idx_dst    = 3'(`CDMA_REG_DST >> 2);
    localparam logic [2:0] idx_len    = 3'(`CDMA_REG_LEN >> 2);
    localparam logic [2:0] idx_launch = 3'(`CDMA_REG_LAUNCH >> 2);
    localparam logic [2:0] idx_status = 3'(`CDMA_REG_STATUS >> 2);

    logic [2:0] reg_idx;
    logic       is_launch;
    logic       is_status;
    addr_t      src_q;
    addr_t      dst_q;
    word_t      len_q;
    logic       r_valid_q;
    word_t      r_data_q;

    assign reg_idx = addr_i[4:2];

    // a read of the launch register asks the controller for a slot
    assign is_launch    = req_i & ~we_i & (reg_idx == idx_launch);
    assign is_status    = ~we_i & (reg_idx == idx_status);
    assign launch_req_o = is_launch;

    // all other accesses are granted at once
    assign gnt_o = req_i & (~is_launch | launch_gnt_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
        end else if (gnt_o && we_i) begin
            case (reg_idx)
                idx_src: src_q <= wdata_i;
                idx_dst: dst_q <= wdata_i;
                idx_len: len_q <= wdata_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= gnt_o;
        end
    end

    // response word, id for a launch, count for status, zero otherwise
    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            if (is_launch) begin
                r_data_q <= launch_id_i;
            end else if (is_status) begin
                r_data_q <= done_count_i;
            end else begin
                r_data_q <= '0;
            end
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_data_o  = r_data_q;

    assign desc_o = '{num_bytes: len_q, dst_addr: dst_q, src_addr: src_q};

    // the controller only grants a pending launch
    gnt_needs_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        launch_gnt_i |-> launch_req_o);

endmodule

`default_nettype wire

/* source/cdma_ctrl.sv */
//////////////////////////////////////////////////
// cdma controller with round-robin launch arbiter,
// id generation, credits and busy tracking
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cdma_cfg.svh"

module cdma_ctrl (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [`CDMA_NUM_PORTS-1:0]            launch_req_i,
    input  cdma_pkg::desc_t [`CDMA_NUM_PORTS-1:0] desc_i,
    output logic [`CDMA_NUM_PORTS-1:0]            launch_gnt_o,
    output cdma_pkg::xfer_id_t                    launch_id_o,
    output cdma_pkg::xfer_id_t                    done_count_o,
    output logic                                  desc_push_o,
    output cdma_pkg::desc_t                       desc_o,
    input  logic                                  credit_i,
    input  logic                                  done_i,
    output logic                                  busy_o,
    output logic [`CDMA_NUM_PORTS-1:0]            term_event_o
);
    import cdma_pkg::*;

    localparam int unsigned num_ports = `CDMA_NUM_PORTS;
    localparam int unsigned credit_w  = $clog2(`CDMA_DESC_DEPTH + 1);

    logic [credit_w-1:0]  credit_q;
    port_idx_t            last_q;
    port_idx_t            sel_idx;
    logic                 sel_valid;
    logic                 issue;
    xfer_id_t             next_id_q;
    xfer_id_t             done_q;
    xfer_id_t             outstanding_q;
    logic [num_ports-1:0] term_q;

    // search starts one past the port granted last
    always_comb begin : proc_rr
        int unsigned cand;
        sel_valid = 1'b0;
        sel_idx   = last_q;
        for (int unsigned k = 1; k <= num_ports; k++) begin
            cand = (32'(last_q) + k) % num_ports;
            if (!sel_valid && launch_req_i[cand]) begin
                sel_valid = 1'b1;
                sel_idx   = port_idx_t'(cand);
            end
        end
    end

    // without credit the requests simply wait
    assign issue = sel_valid & (credit_q != '0);

    always_comb begin
        launch_gnt_o = '0;
        if (issue) begin
            launch_gnt_o[sel_idx] = 1'b1;
        end
    end

    assign desc_push_o = issue;
    assign desc_o      = desc_i[sel_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q      <= credit_w'(`CDMA_DESC_DEPTH);
            last_q        <= port_idx_t'(num_ports - 1);
            next_id_q     <= '0;
            done_q        <= '0;
            outstanding_q <= '0;
            term_q        <= '0;
        end else begin
            credit_q      <= credit_q - credit_w'(issue) + credit_w'(credit_i);
            outstanding_q <= outstanding_q + xfer_id_t'(issue) - xfer_id_t'(done_i);
            term_q        <= {num_ports{done_i}};
            if (issue) begin
                last_q    <= sel_idx;
                next_id_q <= next_id_q + 32'd1;
            end
            if (done_i) begin
                done_q <= done_q + 32'd1;
            end
        end
    end

    assign launch_id_o  = next_id_q;
    assign done_count_o = done_q;
    assign busy_o       = (outstanding_q != '0);
    assign term_event_o = term_q;

    // backend returns no more credits than it was given
    credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= credit_w'(`CDMA_DESC_DEPTH));

    // every completion belongs to a transfer that was issued
    done_issued_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_i |-> outstanding_q != '0);

endmodule

`default_nettype wire

/* source/cdma_backend.sv */
//////////////////////////////////////////////////
// cdma backend with descriptor queue and a word
// copy engine on the memory port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cdma_cfg.svh"

module cdma_backend (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            desc_push_i,
    input  cdma_pkg::desc_t desc_i,
    output logic            credit_o,
    output logic            done_o,
    output logic            mem_req_o,
    output logic            mem_we_o,
    output cdma_pkg::addr_t mem_addr_o,
    output cdma_pkg::word_t mem_wdata_o,
    input  cdma_pkg::word_t mem_rdata_i
);
    import cdma_pkg::*;

    localparam int unsigned depth = `CDMA_DESC_DEPTH;
    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } state_e;

    desc_t            queue_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             pop;
    desc_t            head;
    state_e           state_q;
    state_e           state_d;
    addr_t            src_q;
    addr_t            dst_q;
    word_t            rem_q;
    logic             last_word;

    assign head      = queue_q[rd_ptr_q];
    assign pop       = (state_q == st_idle) && (count_q != '0);
    assign last_word = (rem_q <= 32'd4);

    // each pop frees a queue slot and returns a credit
    assign credit_o = pop;
    assign done_o   = (pop && head.num_bytes == '0) || (state_q == st_write && last_word);

    always_ff @(posedge clk_i) begin
        if (desc_push_i) begin
            queue_q[wr_ptr_q] <= desc_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            state_q  <= st_idle;
        end else begin
            state_q <= state_d;
            count_q <= count_q + cnt_w'(desc_push_i) - cnt_w'(pop);
            if (desc_push_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // read one word, then write it back out on the next cycle
    always_comb begin
        state_d     = state_q;
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        case (state_q)
            st_idle: begin
                if (pop && head.num_bytes != '0) begin
                    state_d = st_read;
                end
            end
            st_read: begin
                mem_req_o  = 1'b1;
                mem_addr_o = src_q;
                state_d    = st_write;
            end
            st_write: begin
                mem_req_o   = 1'b1;
                mem_we_o    = 1'b1;
                mem_addr_o  = dst_q;
                mem_wdata_o = mem_rdata_i;
                state_d     = last_word ? st_idle : st_read;
            end
            default: state_d = st_idle;
        endcase
    end

    // address walkers and remaining bytes
    always_ff @(posedge clk_i) begin
        if (pop) begin
            src_q <= head.src_addr;
            dst_q <= head.dst_addr;
            rem_q <= head.num_bytes;
        end else if (state_q == st_write) begin
            src_q <= src_q + 32'd4;
            dst_q <= dst_q + 32'd4;
            rem_q <= rem_q - 32'd4;
        end
    end

    // credits in the controller keep the queue from overflowing
    no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        desc_push_i |-> count_q < cnt_w'(depth));

endmodule

`default_nettype wire

/* source/cdma_top.sv */
//////////////////////////////////////////////////
// cdma top level with register sets, controller
// and copy backend
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cdma_cfg.svh"

module cdma_top (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [`CDMA_NUM_PORTS-1:0]            req_i,
    input  logic [`CDMA_NUM_PORTS-1:0]            we_i,
    input  cdma_pkg::addr_t [`CDMA_NUM_PORTS-1:0] addr_i,
    input  cdma_pkg::word_t [`CDMA_NUM_PORTS-1:0] wdata_i,
    output logic [`CDMA_NUM_PORTS-1:0]            gnt_o,
    output logic [`CDMA_NUM_PORTS-1:0]            r_valid_o,
    output cdma_pkg::word_t [`CDMA_NUM_PORTS-1:0] r_data_o,
    output logic                                  mem_req_o,
    output logic                                  mem_we_o,
    output cdma_pkg::addr_t                       mem_addr_o,
    output cdma_pkg::word_t                       mem_wdata_o,
    input  cdma_pkg::word_t                       mem_rdata_i,
    output logic                                  busy_o,
    output logic [`CDMA_NUM_PORTS-1:0]            term_event_o
);
    import cdma_pkg::*;

    logic [`CDMA_NUM_PORTS-1:0]  launch_req;
    logic [`CDMA_NUM_PORTS-1:0]  launch_gnt;
    desc_t [`CDMA_NUM_PORTS-1:0] port_desc;
    xfer_id_t                    launch_id;
    xfer_id_t                    done_count;
    logic                        desc_push;
    desc_t                       be_desc;
    logic                        credit;
    logic                        done;

    // one register set per requester, all see the same id and count
    for (genvar i = 0; i < `CDMA_NUM_PORTS; i++) begin : gen_regs
        cdma_cfg_regs i_regs (
            .clk_i        ( clk_i         ),
            .rst_ni       ( rst_ni        ),
            .req_i        ( req_i[i]      ),
            .we_i         ( we_i[i]       ),
            .addr_i       ( addr_i[i]     ),
            .wdata_i      ( wdata_i[i]    ),
            .gnt_o        ( gnt_o[i]      ),
            .r_valid_o    ( r_valid_o[i]  ),
            .r_data_o     ( r_data_o[i]   ),
            .launch_req_o ( launch_req[i] ),
            .launch_gnt_i ( launch_gnt[i] ),
            .launch_id_i  ( launch_id     ),
            .done_count_i ( done_count    ),
            .desc_o       ( port_desc[i]  )
        );
    end

    cdma_ctrl i_ctrl (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .launch_req_i ( launch_req   ),
        .desc_i       ( port_desc    ),
        .launch_gnt_o ( launch_gnt   ),
        .launch_id_o  ( launch_id    ),
        .done_count_o ( done_count   ),
        .desc_push_o  ( desc_push    ),
        .desc_o       ( be_desc      ),
        .credit_i     ( credit       ),
        .done_i       ( done         ),
        .busy_o       ( busy_o       ),
        .term_event_o ( term_event_o )
    );

    cdma_backend i_backend (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .desc_push_i ( desc_push   ),
        .desc_i      ( be_desc     ),
        .credit_o    ( credit      ),
        .done_o      ( done        ),
        .mem_req_o   ( mem_req_o   ),
        .mem_we_o    ( mem_we_o    ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_rdata_i ( mem_rdata_i )
    );

endmodule

`default_nettype wire

/* verif/cdma_tb_clk.sv */
//////////////////////////////////////////////////
// testbench clock and reset generator
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cdma_tb_clk (
    output logic clk_o,
    output logic rst_no
);
    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held low for 8 cycles
    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

/* verif/cdma_tb.sv */
//////////////////////////////////////////////////
// cdma testbench with memory model, register port
// tasks and checks of the copied data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cdma_cfg.svh"

module cdma_tb;
    import cdma_pkg::*;

    localparam int num_ports  = `CDMA_NUM_PORTS;
    localparam int wait_limit = 4000;

    logic                  clk;
    logic                  rst_n;
    logic [num_ports-1:0]  req;
    logic [num_ports-1:0]  we;
    addr_t [num_ports-1:0] addr;
    word_t [num_ports-1:0] wdata;
    logic [num_ports-1:0]  gnt;
    logic [num_ports-1:0]  r_valid;
    word_t [num_ports-1:0] r_data;
    logic                  mem_req;
    logic                  mem_we;
    addr_t                 mem_addr;
    word_t                 mem_wdata;
    word_t                 mem_rdata = '0;
    logic                  busy;
    logic [num_ports-1:0]  term_event;

    word_t       mem [1024];
    word_t       img [1024];
    logic [15:0] lfsr;
    int          err_count = 0;
    int          errs_at_start = 0;
    int          test_count = 0;
    int          test_fails = 0;
    int          term_count = 0;
    int          write_count = 0;
    int          max_gnt_wait = 0;
    logic        timed_out = 1'b0;
    xfer_id_t    next_exp_id;
    xfer_id_t    done_exp;
    addr_t       src_tab [10];
    addr_t       dst_tab [10];
    word_t       len_tab [10];
    xfer_id_t    id_tab [10];

    cdma_tb_clk clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    cdma_top cdma_top_inst (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .req_i        ( req        ),
        .we_i         ( we         ),
        .addr_i       ( addr       ),
        .wdata_i      ( wdata      ),
        .gnt_o        ( gnt        ),
        .r_valid_o    ( r_valid    ),
        .r_data_o     ( r_data     ),
        .mem_req_o    ( mem_req    ),
        .mem_we_o     ( mem_we     ),
        .mem_addr_o   ( mem_addr   ),
        .mem_wdata_o  ( mem_wdata  ),
        .mem_rdata_i  ( mem_rdata  ),
        .busy_o       ( busy       ),
        .term_event_o ( term_event )
    );

    // 1024 word memory, read data one cycle after the request
    always @(posedge clk) begin
        if (mem_req && !mem_we) begin
            mem_rdata <= mem[mem_addr[11:2]];
        end
        if (mem_req && mem_we) begin
            mem[mem_addr[11:2]] <= mem_wdata;
        end
    end

    // counts memory writes and termination events
    always @(negedge clk) begin
        if (mem_req && mem_we) begin
            write_count++;
        end
        if (term_event != '0) begin
            term_count++;
            check_bit("term_event_o on every port", &term_event, 1'b1);
        end
    end

    initial begin
        wait (timed_out);
        $display("Something failed");
        $finish;
    end

    task automatic stall(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        timed_out = 1'b1;
        // park here, the watcher ends the run
        forever @(posedge clk);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_id(input string what, input xfer_id_t got, input xfer_id_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output word_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // expected word at destination address a, from the image before the copy
    function automatic word_t cdma_ref_copy(input addr_t src, input addr_t dst, input addr_t a);
        addr_t from;
        from = src + (a - dst);
        return img[from[11:2]];
    endfunction

    // position in the round-robin order after the port granted last
    function automatic int rr_rank(input int p, input int last);
        return (p - last - 1 + 2 * num_ports) % num_ports;
    endfunction

    task automatic reg_access(input int p, input logic w, input addr_t a, input word_t d,
                              output word_t rd);
        int cnt;
        @(posedge clk);
        req[p]   <= 1'b1;
        we[p]    <= w;
        addr[p]  <= a;
        wdata[p] <= d;
        cnt = 0;
        @(negedge clk);
        while (!gnt[p] && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!gnt[p]) begin
            stall("a register grant");
        end
        if (cnt > max_gnt_wait) begin
            max_gnt_wait = cnt;
        end
        @(posedge clk);
        req[p] <= 1'b0;
        @(negedge clk);
        check_bit("r_valid_o after grant", r_valid[p], 1'b1);
        rd = r_data[p];
    endtask

    task automatic reg_write(input int p, input addr_t a, input word_t d);
        word_t rd;
        reg_access(p, 1'b1, a, d, rd);
        check_word("write response", rd, '0);
    endtask

    task automatic read_status(input int p, output xfer_id_t cnt);
        reg_access(p, 1'b0, `CDMA_REG_STATUS, '0, cnt);
    endtask

    task automatic launch(input int p, input addr_t src, input addr_t dst, input word_t len,
                          output xfer_id_t id);
        reg_write(p, `CDMA_REG_SRC, src);
        reg_write(p, `CDMA_REG_DST, dst);
        reg_write(p, `CDMA_REG_LEN, len);
        reg_access(p, 1'b0, `CDMA_REG_LAUNCH, '0, id);
    endtask

    task automatic launch_burst(input int p, input int first, input int n);
        for (int k = first; k < first + n; k++) begin
            launch(p, src_tab[k], dst_tab[k], len_tab[k], id_tab[k]);
        end
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (busy && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (busy) begin
            stall("busy_o to drop");
        end
        // lets the event monitor see the last termination pulse
        @(negedge clk);
    endtask

    // sources below 0x800, destinations above, 32 words apart
    task automatic make_descriptors(input int n);
        word_t r;
        for (int k = 0; k < n; k++) begin
            random_bits(3, r);
            src_tab[k] = addr_t'(k * 128);
            dst_tab[k] = 32'h800 + addr_t'(k * 128);
            len_tab[k] = (r + 32'd4) << 2;
        end
    endtask

    task automatic check_region(input addr_t src, input addr_t dst, input word_t len);
        addr_t a;
        for (int unsigned k = 0; k < (len >> 2); k++) begin
            a = dst + (k << 2);
            check_word("destination word", mem[a[11:2]], cdma_ref_copy(src, dst, a));
        end
        a = dst + len;
        check_word("word after the region", mem[a[11:2]], img[a[11:2]]);
    endtask

    task automatic start_test();
        for (int i = 0; i < 1024; i++) begin
            img[i] = mem[i];
        end
        errs_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == errs_at_start) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: FAIL", test_count, name);
        end
    endtask

    initial begin
        word_t      w;
        xfer_id_t   id;
        xfer_id_t   cnt;
        int         tc_before;
        int         wr_before;
        int         wcnt;
        logic [9:0] seen;
        xfer_id_t   off;
        req   <= '0;
        we    <= '0;
        addr  <= '0;
        wdata <= '0;
        lfsr = 16'd18325;
        for (int i = 0; i < 1024; i++) begin
            random_bits(32, w);
            mem[i] <= w;
        end
        next_exp_id = '0;
        done_exp    = '0;
        wcnt = 0;
        @(negedge clk);
        while (!rst_n && wcnt < wait_limit) begin
            @(negedge clk);
            wcnt++;
        end
        if (!rst_n) begin
            stall("reset release");
        end

        start_test();
        check_bit("gnt_o after reset", |gnt, 1'b0);
        check_bit("r_valid_o after reset", |r_valid, 1'b0);
        check_bit("busy_o after reset", busy, 1'b0);
        check_bit("term_event_o after reset", |term_event, 1'b0);
        check_bit("mem_req_o after reset", mem_req, 1'b0);
        read_status(0, cnt);
        check_id("status after reset", cnt, '0);
        end_test("reset state");

        start_test();
        make_descriptors(1);
        len_tab[0] = 32'd32;
        tc_before = term_count;
        launch(0, src_tab[0], dst_tab[0], len_tab[0], id);
        check_id("launch id", id, next_exp_id);
        check_bit("busy_o during copy", busy, 1'b1);
        next_exp_id++;
        wait_idle();
        done_exp++;
        read_status(0, cnt);
        check_id("status", cnt, done_exp);
        check_region(src_tab[0], dst_tab[0], len_tab[0]);
        check_id("termination events", xfer_id_t'(term_count - tc_before), 32'd1);
        end_test("single transfer");

        start_test();
        make_descriptors(num_ports);
        tc_before = term_count;
        fork
            launch(0, src_tab[0], dst_tab[0], len_tab[0], id_tab[0]);
            launch(1, src_tab[1], dst_tab[1], len_tab[1], id_tab[1]);
            launch(2, src_tab[2], dst_tab[2], len_tab[2], id_tab[2]);
        join
        // port 0 was granted last in the single transfer
        for (int p = 0; p < num_ports; p++) begin
            check_id("concurrent launch id", id_tab[p], next_exp_id + xfer_id_t'(rr_rank(p, 0)));
        end
        next_exp_id += xfer_id_t'(num_ports);
        wait_idle();
        done_exp += xfer_id_t'(num_ports);
        read_status(1, cnt);
        check_id("status", cnt, done_exp);
        for (int p = 0; p < num_ports; p++) begin
            check_region(src_tab[p], dst_tab[p], len_tab[p]);
        end
        check_id("termination events", xfer_id_t'(term_count - tc_before), 32'd3);
        end_test("concurrent launches");

        start_test();
        make_descriptors(10);
        tc_before = term_count;
        max_gnt_wait = 0;
        fork
            launch_burst(0, 0, 4);
            launch_burst(1, 4, 3);
            launch_burst(2, 7, 3);
        join
        seen = '0;
        for (int k = 0; k < 10; k++) begin
            off = id_tab[k] - next_exp_id;
            if (off < 10) begin
                seen[off[3:0]] = 1'b1;
            end
        end
        check_bit("ten distinct consecutive ids", &seen, 1'b1);
        check_bit("launches held back by credits", max_gnt_wait > 3, 1'b1);
        next_exp_id += 32'd10;
        wait_idle();
        done_exp += 32'd10;
        read_status(2, cnt);
        check_id("status", cnt, done_exp);
        for (int k = 0; k < 10; k++) begin
            check_region(src_tab[k], dst_tab[k], len_tab[k]);
        end
        check_id("termination events", xfer_id_t'(term_count - tc_before), 32'd10);
        end_test("credit back-pressure");

        start_test();
        tc_before = term_count;
        wr_before = write_count;
        launch(1, 32'h100, 32'h900, '0, id);
        check_id("zero length launch id", id, next_exp_id);
        next_exp_id++;
        wait_idle();
        done_exp++;
        read_status(2, cnt);
        check_id("status", cnt, done_exp);
        check_bit("no memory write", write_count == wr_before, 1'b1);
        check_region(32'h100, 32'h900, '0);
        check_id("termination events", xfer_id_t'(term_count - tc_before), 32'd1);
        end_test("zero length");

        $display("tests %0d, failed %0d, errors %0d", test_count, test_fails, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cdma.f */
+incdir+source
source/cdma_pkg.sv
source/cdma_cfg_regs.sv
source/cdma_ctrl.sv
source/cdma_backend.sv
source/cdma_top.sv
verif/cdma_tb_clk.sv
verif/cdma_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cdma testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cdma_tb -f cdma.f -o cdma_sim

./obj_dir/cdma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi
